// File: design/llr_pkg.sv
package llr_pkg;

    // Soft value and message format
    localparam int MSG_W    = 6;
    localparam int MSG_MAX  = 31;
    localparam int MAG_W    = MSG_W - 1;

    // Column indexing, up to 32 columns per row
    localparam int IDX_W    = 5;
    localparam int MAX_COLS = 32;

    typedef logic signed [MSG_W-1:0] msg_t;
    typedef logic [MAG_W-1:0]        mag_t;

    // Compressed check message, one memory word of 47 bits
    typedef struct packed {
        mag_t                min1;
        mag_t                min2;
        logic [IDX_W-1:0]    min1_idx;
        logic [MAX_COLS-1:0] signs;
    } ecomp_t;

    // Clamp a one-bit-wider sum to the symmetric message range
    function automatic msg_t sat_wide(input logic signed [MSG_W:0] v);
        if (v > MSG_MAX)
            return msg_t'(MSG_MAX);
        else if (v < -MSG_MAX)
            return msg_t'(-MSG_MAX);
        else
            return msg_t'(v);
    endfunction

endpackage

// File: design/row_ctrl_pkg.sv
package row_ctrl_pkg;

    // Address fields of a block row
    localparam int LAYER_W = 2;
    localparam int ADDR_W  = 5;

    // Incoming request, valid is a one-cycle strobe
    typedef struct packed {
        logic               valid;
        logic [LAYER_W-1:0] layer;
        logic [ADDR_W-1:0]  addr;
    } row_req_t;

    // Outgoing result marker, same layout as the request
    typedef struct packed {
        logic               valid;
        logic [LAYER_W-1:0] layer;
        logic [ADDR_W-1:0]  addr;
    } row_rsp_t;

endpackage

// File: design/check_msg_mem.sv
module check_msg_mem #(
    parameter int  DEPTH = 40,
    localparam int AW    = $clog2(DEPTH)
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            rd_en,
    input  logic [AW-1:0]   rd_idx,
    output llr_pkg::ecomp_t rd_data,
    input  logic            wr_en,
    input  logic [AW-1:0]   wr_idx,
    input  llr_pkg::ecomp_t wr_data
);
    import llr_pkg::*;

    ecomp_t           mem [DEPTH];
    logic [DEPTH-1:0] written;

    // One flag per entry, set on the first write after reset
    always_ff @(posedge clk)
    begin
        if (!rst)
            written <= '0;
        else if (wr_en)
            written[wr_idx] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_idx] <= wr_data;
    end

    // Registered read, old contents on a same-cycle write
    // Fresh entries give a zero record, so all messages start at zero
    always_ff @(posedge clk)
    begin
        if (rd_en)
            rd_data <= written[rd_idx] ? mem[rd_idx] : '0;
    end

endmodule

// File: design/check_msg_recover.sv
module check_msg_recover #(
    parameter int WC = 8
) (
    input  llr_pkg::ecomp_t        ecomp,
    output llr_pkg::msg_t [WC-1:0] msgs
);
    import llr_pkg::*;

    ////////////////////////////////////////////////////
    // Per-column message recovery
    ////////////////////////////////////////////////////

    for (genvar i = 0; i < WC; i++)
    begin : g_col
        mag_t mag;
        msg_t pos;

        // The min1 column sees the second minimum
        assign mag = (ecomp.min1_idx == IDX_W'(i)) ? ecomp.min2 : ecomp.min1;
        assign pos = $signed({1'b0, mag});

        // Sign bit already excludes the column itself
        assign msgs[i] = ecomp.signs[i] ? -pos : pos;
    end

endmodule

// File: design/min_sum_kernel.sv
module min_sum_kernel #(
    parameter int WC = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  llr_pkg::msg_t [WC-1:0] llr,
    input  llr_pkg::msg_t [WC-1:0] old_msgs,
    output llr_pkg::ecomp_t        ecomp,
    output llr_pkg::msg_t [WC-1:0] q_delayed
);
    import llr_pkg::*;

    localparam int HALF = WC / 2;

    // Two smallest magnitudes over a group of columns
    typedef struct packed {
        mag_t             min1;
        mag_t             min2;
        logic [IDX_W-1:0] idx;
    } part_t;

    msg_t [WC-1:0]       q_s1;
    msg_t [WC-1:0]       q_dly [3];
    mag_t [WC-1:0]       q_mag;
    logic [WC-1:0]       q_neg;
    logic [WC-1:0]       sign_s2;
    part_t               lo_part;
    part_t               hi_part;
    part_t               lo_s2;
    part_t               hi_s2;
    part_t               row_part;
    logic                parity;
    logic [MAX_COLS-1:0] signs_next;

    function automatic part_t leaf(input mag_t mag, input int col);
        part_t p;
        p.min1 = mag;
        p.min2 = '1;
        p.idx  = IDX_W'(col);
        return p;
    endfunction

    // a covers the lower columns and wins ties
    function automatic part_t merge(input part_t a, input part_t b);
        part_t m;
        if (b.min1 < a.min1)
        begin
            m.min1 = b.min1;
            m.idx  = b.idx;
            m.min2 = (a.min1 < b.min2) ? a.min1 : b.min2;
        end
        else
        begin
            m.min1 = a.min1;
            m.idx  = a.idx;
            m.min2 = (b.min1 < a.min2) ? b.min1 : a.min2;
        end
        return m;
    endfunction

    ////////////////////////////////////////////////////
    // Stage 1: Q = L - old, and the Q delay line
    ////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < WC; i++)
            q_s1[i] <= sat_wide({llr[i][MSG_W-1], llr[i]} - {old_msgs[i][MSG_W-1], old_msgs[i]});
        q_dly[0] <= q_s1;
        q_dly[1] <= q_dly[0];
        q_dly[2] <= q_dly[1];
    end

    assign q_delayed = q_dly[2];

    ////////////////////////////////////////////////////
    // Stage 2: sign, magnitude and minima per half
    ////////////////////////////////////////////////////

    // Zero counts as positive
    for (genvar i = 0; i < WC; i++)
    begin : g_mag
        assign q_neg[i] = q_s1[i][MSG_W-1];
        assign q_mag[i] = q_neg[i] ? mag_t'(-q_s1[i]) : mag_t'(q_s1[i]);
    end

    always_comb
    begin
        lo_part = leaf(q_mag[0], 0);
        for (int i = 1; i < HALF; i++)
            lo_part = merge(lo_part, leaf(q_mag[i], i));
        hi_part = leaf(q_mag[HALF], HALF);
        for (int i = HALF + 1; i < WC; i++)
            hi_part = merge(hi_part, leaf(q_mag[i], i));
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            sign_s2 <= '0;
            lo_s2   <= '0;
            hi_s2   <= '0;
        end
        else
        begin
            sign_s2 <= q_neg;
            lo_s2   <= lo_part;
            hi_s2   <= hi_part;
        end
    end

    ////////////////////////////////////////////////////
    // Stage 3: merge halves into the compressed word
    ////////////////////////////////////////////////////

    assign row_part = merge(lo_s2, hi_s2);
    assign parity   = ^sign_s2;

    // Each column gets the product of the other signs
    always_comb
    begin
        signs_next = '0;
        for (int i = 0; i < WC; i++)
            signs_next[i] = parity ^ sign_s2[i];
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
            ecomp <= '0;
        else
        begin
            ecomp.min1     <= row_part.min1;
            ecomp.min2     <= row_part.min2;
            ecomp.min1_idx <= row_part.idx;
            ecomp.signs    <= signs_next;
        end
    end

endmodule

// File: design/llr_update.sv
module llr_update #(
    parameter int WC = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   valid,
    input  llr_pkg::msg_t [WC-1:0] q,
    input  llr_pkg::msg_t [WC-1:0] new_msgs,
    output llr_pkg::msg_t [WC-1:0] llr_out
);
    import llr_pkg::*;

    msg_t [WC-1:0] upd;

    // Updated LLR = extrinsic Q plus the new check message
    for (genvar i = 0; i < WC; i++)
    begin : g_col
        assign upd[i] = sat_wide({q[i][MSG_W-1], q[i]} + {new_msgs[i][MSG_W-1], new_msgs[i]});
    end

    // Output held at zero outside result cycles
    always_ff @(posedge clk)
    begin
        if (!rst)
            llr_out <= '0;
        else if (valid)
            llr_out <= upd;
        else
            llr_out <= '0;
    end

endmodule

// File: design/siso_row_unit.sv
module siso_row_unit #(
    parameter int WC        = 8,
    parameter int ROW_DEPTH = 20,
    parameter int LAYERS    = 2
) (
    input  logic                     clk,
    input  logic                     rst,
    input  row_ctrl_pkg::row_req_t   req,
    input  llr_pkg::msg_t [WC-1:0]   llr_in,
    output row_ctrl_pkg::row_rsp_t   rsp,
    output llr_pkg::msg_t [WC-1:0]   llr_out
);
    import llr_pkg::*;
    import row_ctrl_pkg::*;

    localparam int DEPTH     = ROW_DEPTH * LAYERS;
    localparam int MEM_AW    = $clog2(DEPTH);
    localparam int STAGES    = 8;
    localparam int WR_STAGE  = 6;
    localparam int UPD_STAGE = 7;

    // addr_q[k] holds the request k cycles after its strobe
    row_req_t          addr_q [1:STAGES];

    msg_t [WC-1:0]     llr_s1;
    msg_t [WC-1:0]     llr_s2;
    msg_t [WC-1:0]     llr_s3;
    msg_t [WC-1:0]     old_msgs;
    msg_t [WC-1:0]     old_msgs_r;
    msg_t [WC-1:0]     new_msgs;
    msg_t [WC-1:0]     new_msgs_r;
    msg_t [WC-1:0]     q_delayed;

    ecomp_t            mem_rd_data;
    ecomp_t            ecomp_new;
    logic              mem_rd_en;
    logic              mem_wr_en;
    logic [MEM_AW-1:0] mem_rd_idx;
    logic [MEM_AW-1:0] mem_wr_idx;

    // Flat memory index, layers stacked one after the other
    function automatic logic [MEM_AW-1:0] mem_index(input row_req_t r);
        return MEM_AW'(r.layer) * MEM_AW'(ROW_DEPTH) + MEM_AW'(r.addr);
    endfunction

    ////////////////////////////////////////////////////
    // Address queue
    ////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            for (int k = 1; k <= STAGES; k++)
                addr_q[k] <= '0;
        end
        else
        begin
            addr_q[1] <= req;
            for (int k = 2; k <= STAGES; k++)
                addr_q[k] <= addr_q[k-1];
        end
    end

    ////////////////////////////////////////////////////
    // Data alignment registers
    ////////////////////////////////////////////////////

    // LLRs wait two cycles for the old messages
    always_ff @(posedge clk)
    begin
        if (req.valid)
            llr_s1 <= llr_in;
        llr_s2     <= llr_s1;
        llr_s3     <= llr_s2;
        old_msgs_r <= old_msgs;
        new_msgs_r <= new_msgs;
    end

    ////////////////////////////////////////////////////
    // Check-message memory
    ////////////////////////////////////////////////////

    assign mem_rd_en  = addr_q[1].valid;
    assign mem_rd_idx = mem_index(addr_q[1]);
    assign mem_wr_en  = addr_q[WR_STAGE].valid;
    assign mem_wr_idx = mem_index(addr_q[WR_STAGE]);

    check_msg_mem #(
        .DEPTH   (DEPTH)
    ) u_mem (
        .clk     (clk),
        .rst     (rst),
        .rd_en   (mem_rd_en),
        .rd_idx  (mem_rd_idx),
        .rd_data (mem_rd_data),
        .wr_en   (mem_wr_en),
        .wr_idx  (mem_wr_idx),
        .wr_data (ecomp_new)
    );

    ////////////////////////////////////////////////////
    // Recovery, kernel and update
    ////////////////////////////////////////////////////

    // Messages from the previous iteration
    check_msg_recover #(.WC(WC)) u_recover_old (
        .ecomp (mem_rd_data),
        .msgs  (old_msgs)
    );

    min_sum_kernel #(.WC(WC)) u_kernel (
        .clk       (clk),
        .rst       (rst),
        .llr       (llr_s3),
        .old_msgs  (old_msgs_r),
        .ecomp     (ecomp_new),
        .q_delayed (q_delayed)
    );

    // Messages just written back
    check_msg_recover #(.WC(WC)) u_recover_new (
        .ecomp (ecomp_new),
        .msgs  (new_msgs)
    );

    llr_update #(.WC(WC)) u_update (
        .clk      (clk),
        .rst      (rst),
        .valid    (addr_q[UPD_STAGE].valid),
        .q        (q_delayed),
        .new_msgs (new_msgs_r),
        .llr_out  (llr_out)
    );

    always_comb
    begin
        rsp.valid = addr_q[STAGES].valid;
        rsp.layer = addr_q[STAGES].layer;
        rsp.addr  = addr_q[STAGES].addr;
    end

endmodule

// File: tb/row_unit_properties.sv
module row_unit_properties #(
    parameter int WC = 8
) (
    input logic                   clk,
    input logic                   rst,
    input row_ctrl_pkg::row_req_t req,
    input row_ctrl_pkg::row_rsp_t rsp,
    input llr_pkg::msg_t [WC-1:0] llr_out,
    input logic                   mem_wr_en
);
    timeunit 1ns;
    timeprecision 1ps;

    // Number of failed properties so far
    int failures = 0;

    //////////////////////////////////////////////////
    // Pipeline latency
    //////////////////////////////////////////////////

    a_rsp_latency: assert property (
        @(posedge clk) disable iff (!rst) req.valid |-> ##8 rsp.valid
    )
    else
    begin
        $error("rsp.valid did not follow req.valid by 8 cycles");
        failures++;
    end

    a_rsp_source: assert property (
        @(posedge clk) disable iff (!rst) rsp.valid |-> $past(req.valid, 8)
    )
    else
    begin
        $error("rsp.valid without a strobe 8 cycles earlier");
        failures++;
    end

    // Output quiet between results
    a_llr_quiet: assert property (
        @(posedge clk) disable iff (!rst) !rsp.valid |-> (llr_out == '0)
    )
    else
    begin
        $error("llr_out not zero while rsp.valid is low");
        failures++;
    end

    //////////////////////////////////////////////////
    // Memory write-back
    //////////////////////////////////////////////////

    a_wr_latency: assert property (
        @(posedge clk) disable iff (!rst) req.valid |-> ##6 mem_wr_en
    )
    else
    begin
        $error("Memory write missing 6 cycles after a strobe");
        failures++;
    end

    a_wr_source: assert property (
        @(posedge clk) disable iff (!rst) mem_wr_en |-> $past(req.valid, 6)
    )
    else
    begin
        $error("Memory write without a strobe 6 cycles earlier");
        failures++;
    end

endmodule

// File: tb/row_unit_tb.sv
module row_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import llr_pkg::*;
    import row_ctrl_pkg::*;

    localparam int WC         = 8;
    localparam int ROW_DEPTH  = 20;
    localparam int LAYERS     = 2;
    localparam int DEPTH      = ROW_DEPTH * LAYERS;
    localparam int LATENCY    = 8;
    localparam int N_FIXED    = 13;
    localparam int N_RANDOM   = 40;
    localparam int NUM_ROWS   = N_FIXED + N_RANDOM;
    localparam int RAND_ADDRS = 6;

    typedef msg_t [WC-1:0] msg_vec_t;

    // One table row with its expected result
    typedef struct packed {
        logic [LAYER_W-1:0] layer;
        logic [ADDR_W-1:0]  addr;
        logic [7:0]         gap;
        msg_vec_t           llr;
        msg_vec_t           exp_llr;
    } stim_t;

    logic     clk;
    logic     rst;
    row_req_t req;
    msg_vec_t llr_in;
    row_rsp_t rsp;
    msg_vec_t llr_out;

    stim_t    stim [NUM_ROWS];
    int       strobe_at [NUM_ROWS];
    int       strobe_q [$];
    int       next_strobe = 0;
    int       cycle       = 0;
    int       limit       = 0;
    int       rsp_count   = 0;
    int       pass_count  = 0;
    int       errors      = 0;
    logic     table_ready = 1'b0;

    // Reference copy of the compressed check messages
    int            ref_min1 [DEPTH];
    int            ref_min2 [DEPTH];
    int            ref_idx [DEPTH];
    logic [WC-1:0] ref_signs [DEPTH];
    logic          ref_written [DEPTH];

    siso_row_unit #(
        .WC        (WC),
        .ROW_DEPTH (ROW_DEPTH),
        .LAYERS    (LAYERS)
    ) UUT (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .llr_in  (llr_in),
        .rsp     (rsp),
        .llr_out (llr_out)
    );

    bind siso_row_unit row_unit_properties #(.WC(WC)) props (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .rsp       (rsp),
        .llr_out   (llr_out),
        .mem_wr_en (mem_wr_en)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic int clamp(input int v);
        if (v > MSG_MAX)
            return MSG_MAX;
        if (v < -MSG_MAX)
            return -MSG_MAX;
        return v;
    endfunction

    function automatic msg_vec_t vec8(input int a0, a1, a2, a3, a4, a5, a6, a7);
        msg_vec_t v;
        v[0] = msg_t'(a0);
        v[1] = msg_t'(a1);
        v[2] = msg_t'(a2);
        v[3] = msg_t'(a3);
        v[4] = msg_t'(a4);
        v[5] = msg_t'(a5);
        v[6] = msg_t'(a6);
        v[7] = msg_t'(a7);
        return v;
    endfunction

    function automatic msg_vec_t random_vec();
        msg_vec_t v;
        for (int i = 0; i < WC; i++)
            v[i] = msg_t'(int'($urandom_range(62)) - 31);
        return v;
    endfunction

    // One row visit, updates the reference store
    function automatic msg_vec_t model_row(input int key, input msg_vec_t l);
        int            q [WC];
        int            mag [WC];
        int            old_m;
        int            new_m;
        int            m1;
        int            m2;
        int            ix;
        logic [WC-1:0] neg;
        msg_vec_t      res;
        for (int i = 0; i < WC; i++)
        begin
            old_m = 0;
            if (ref_written[key])
            begin
                old_m = (i == ref_idx[key]) ? ref_min2[key] : ref_min1[key];
                if (ref_signs[key][i])
                    old_m = -old_m;
            end
            q[i]   = clamp(int'(l[i]) - old_m);
            neg[i] = q[i] < 0;
            mag[i] = neg[i] ? -q[i] : q[i];
        end
        // Lowest index wins a tie
        m1 = MSG_MAX + 1;
        ix = 0;
        for (int i = 0; i < WC; i++)
        begin
            if (mag[i] < m1)
            begin
                m1 = mag[i];
                ix = i;
            end
        end
        m2 = MSG_MAX + 1;
        for (int i = 0; i < WC; i++)
        begin
            if (i != ix && mag[i] < m2)
                m2 = mag[i];
        end
        ref_min1[key]    = m1;
        ref_min2[key]    = m2;
        ref_idx[key]     = ix;
        ref_signs[key]   = neg ^ {WC{^neg}};
        ref_written[key] = 1'b1;
        for (int i = 0; i < WC; i++)
        begin
            new_m = (i == ix) ? m2 : m1;
            if (ref_signs[key][i])
                new_m = -new_m;
            res[i] = msg_t'(clamp(q[i] + new_m));
        end
        return res;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////

    // Same entry again before its write-back lands
    function automatic logic reused_too_soon(input int row, input int layer, input int addr);
        for (int j = 0; j < row; j++)
        begin
            if (int'(stim[j].layer) == layer && int'(stim[j].addr) == addr &&
                strobe_at[row] - strobe_at[j] < LATENCY)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic add_row(input int i, input int layer, input int addr, input int gap,
                           input msg_vec_t l);
        strobe_at[i] = next_strobe;
        if (reused_too_soon(i, layer, addr))
        begin
            $display("Stimulus row %0d reuses layer %0d address %0d too soon", i, layer, addr);
            errors++;
        end
        stim[i].layer   = LAYER_W'(layer);
        stim[i].addr    = ADDR_W'(addr);
        stim[i].gap     = 8'(gap);
        stim[i].llr     = l;
        stim[i].exp_llr = model_row(layer * ROW_DEPTH + addr, l);
        next_strobe     = next_strobe + 1 + gap;
        limit           = limit + LATENCY + gap;
    endtask

    task automatic build_table();
        int layer;
        int addr;
        for (int k = 0; k < DEPTH; k++)
            ref_written[k] = 1'b0;
        // Tie at columns 1 and 3, saturation at columns 5 and 6
        add_row(0, 0, 0, 4, vec8(10, -3, 7, 3, -20, 31, -31, -15));
        add_row(1, 1, 19, 4, vec8(0, 5, -5, 12, -12, 2, -2, 20));
        // Later iterations of row 0 fed with its own output
        add_row(2, 0, 0, 8, stim[0].exp_llr);
        add_row(3, 0, 0, 8, stim[2].exp_llr);
        add_row(4, 0, 0, 8, stim[3].exp_llr);
        // Back-to-back burst over both layers
        for (int i = 5; i < N_FIXED; i++)
            add_row(i, i % 2, i + 3, (i == N_FIXED - 1) ? 4 : 0, random_vec());
        for (int i = N_FIXED; i < NUM_ROWS; i++)
        begin
            strobe_at[i] = next_strobe;
            layer = int'($urandom_range(LAYERS - 1));
            addr  = int'($urandom_range(RAND_ADDRS - 1));
            while (reused_too_soon(i, layer, addr))
            begin
                layer = int'($urandom_range(LAYERS - 1));
                addr  = int'($urandom_range(RAND_ADDRS - 1));
            end
            add_row(i, layer, addr, int'($urandom_range(2)), random_vec());
        end
        limit       = limit + 100;
        table_ready = 1'b1;
    endtask

    task automatic drive_rows();
        row_req_t r;
        for (int i = 0; i < NUM_ROWS; i++)
        begin
            r.valid = 1'b1;
            r.layer = stim[i].layer;
            r.addr  = stim[i].addr;
            @(posedge clk);
            req    <= r;
            llr_in <= stim[i].llr;
            for (int g = 0; g < int'(stim[i].gap); g++)
            begin
                @(posedge clk);
                req    <= '0;
                llr_in <= '0;
            end
        end
        @(posedge clk);
        req    <= '0;
        llr_in <= '0;
    endtask

    //////////////////////////////////////////////////
    // Response checking
    //////////////////////////////////////////////////

    task automatic check_response();
        int    lat;
        int    bad;
        stim_t s;
        bad = 0;
        if (rsp_count >= NUM_ROWS)
        begin
            $display("Unexpected response at cycle %0d with no request outstanding", cycle);
            errors++;
        end
        else
        begin
            s = stim[rsp_count];
            if (strobe_q.size() == 0)
                lat = -1;
            else
                lat = cycle - strobe_q.pop_front();
            if (rsp.layer != s.layer)
            begin
                $display("Mismatch rsp.layer: expected 0x%h, got 0x%h", s.layer, rsp.layer);
                bad++;
            end
            if (rsp.addr != s.addr)
            begin
                $display("Mismatch rsp.addr: expected 0x%h, got 0x%h", s.addr, rsp.addr);
                bad++;
            end
            if (llr_out != s.exp_llr)
            begin
                $display("Mismatch llr_out: expected 0x%h, got 0x%h", s.exp_llr, llr_out);
                bad++;
            end
            if (lat != LATENCY)
            begin
                $display("Response %0d came %0d cycles after its strobe instead of %0d",
                         rsp_count, lat, LATENCY);
                bad++;
            end
            if (bad == 0)
                pass_count++;
            errors = errors + bad;
            $display("Test %0d layer %0d addr %0d: %s", rsp_count, s.layer, s.addr,
                     (bad == 0) ? "pass" : "FAIL");
            rsp_count++;
        end
    endtask

    always @(posedge clk)
        cycle <= cycle + 1;

    // Sampled mid-cycle, away from the driving edge
    always @(negedge clk)
    begin
        if (rst)
        begin
            if (req.valid)
                strobe_q.push_back(cycle);
            if (rsp.valid)
                check_response();
            else if (llr_out != '0)
            begin
                $display("Mismatch llr_out: expected 0x0, got 0x%h while rsp.valid is low",
                         llr_out);
                errors++;
            end
        end
    end

    //////////////////////////////////////////////////
    // Run control
    //////////////////////////////////////////////////

    initial
    begin
        void'($urandom(32'h254c));
        rst    = 1'b0;
        req    = '0;
        llr_in = '0;
        build_table();
        repeat (16) @(posedge clk);
        rst <= 1'b1;
        // Quiet stretch before the first strobe
        repeat (6) @(posedge clk);
        drive_rows();
        wait (rsp_count == NUM_ROWS);
        repeat (10) @(posedge clk);
        errors = errors + UUT.props.failures;
        $display("Rows: %0d, passed: %0d, failed checks: %0d", NUM_ROWS, pass_count, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    initial
    begin
        wait (table_ready);
        wait (cycle >= limit);
        $display("Timeout at cycle %0d, responses missing with %0d of %0d received",
                 cycle, rsp_count, NUM_ROWS);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: sources.f
design/llr_pkg.sv
design/row_ctrl_pkg.sv
design/check_msg_mem.sv
design/check_msg_recover.sv
design/min_sum_kernel.sv
design/llr_update.sv
design/siso_row_unit.sv
tb/row_unit_properties.sv
tb/row_unit_tb.sv

// File: Makefile
# Verilator flow for the SISO row unit

VERILATOR  ?= verilator
TOP        ?= row_unit_tb
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/1ps
PASS_MSG   ?= Finished with no errors
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --timing --timescale $(TIMESCALE) \
		--top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
